/* ex_pkg.sv */
// Execute stage package
// Opcode, ALU, branch and load encodings, the instruction word views
// and the bundles passed between the execute stage blocks

package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_t;

  // Values are the funct3 codes
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Store funct3 shares LB/LH/LW codes for width
  typedef enum logic [2:0] {
    LB   = 3'b000,
    LH   = 3'b001,
    LW   = 3'b010,
    LBU  = 3'b100,
    LHU  = 3'b101,
    NONE = 3'b111
  } load_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_M    = 2'b01,
    FWD_W    = 2'b10
  } fwd_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_word_u;

  typedef struct packed {
    logic        valid;
    instr_word_u instr;
    word_t       pc;
    word_t       rs1_data;
    word_t       rs2_data;
  } id_ex_t;

  typedef struct packed {
    fwd_sel_t rs1_fwd;
    fwd_sel_t rs2_fwd;
    word_t    rd_data_mem;
    word_t    rd_data_wb;
  } bypass_t;

  typedef struct packed {
    alu_op_t  alu_op;
    logic     wen;
    reg_idx_t rd;
    logic     dren;
    logic     dwen;
    load_t    load_type;
    logic     branch_instr;
    branch_t  branch_type;
    logic     jump_instr;
    logic     jalr;
    word_t    imm;
  } ex_ctrl_t;

  typedef struct packed {
    logic     valid;
    ex_ctrl_t ctrl;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_a;
    word_t    alu_b;
    word_t    pc;
    word_t    pc4;
  } ex_ops_t;

  typedef struct packed {
    logic  branch_taken;
    word_t jump_addr;
    word_t resolved_addr;
  } br_res_t;

  typedef struct packed {
    logic       valid;
    logic       wen;
    reg_idx_t   rd;
    word_t      result;
    word_t      mem_addr;
    word_t      store_data;
    logic [3:0] byte_en;
    logic       dren;
    logic       dwen;
    load_t      load_type;
    logic       branch_instr;
    logic       branch_taken;
    logic       jump_instr;
    word_t      jump_addr;
    word_t      resolved_addr;
    word_t      pc;
  } ex_mem_t;

endpackage

/* operand_decode.sv */
// Operand decode for the execute stage
// Splits the instruction word into controls and an immediate and
// resolves both register sources against the bypass values

`timescale 1ns/1ps

module operand_decode (
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::bypass_t bypass,
  output ex_pkg::ex_ops_t ops
);

  import ex_pkg::*;

  instr_word_u instr;
  ex_ctrl_t    ctrl;
  word_t       rs1_val, rs2_val;
  logic        use_imm;

  function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Memory result is younger, so it is checked first
  function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
    word_t val;
    if (sel == FWD_M)
      val = mem_val;
    else if (sel == FWD_W)
      val = wb_val;
    else
      val = reg_val;
    return val;
  endfunction

  assign instr = id_ex.instr;

  always_comb begin
    ctrl             = '0;
    ctrl.alu_op      = ALU_ADD;
    ctrl.load_type   = NONE;
    ctrl.branch_type = BEQ;
    ctrl.rd          = instr.r_fmt.rd;
    use_imm          = 1'b0;

    case (instr.r_fmt.opcode)
      LUI, AUIPC: begin
        ctrl.imm    = {instr.u_fmt.imm, 12'b0};
        ctrl.alu_op = (instr.u_fmt.opcode == LUI) ? ALU_COPY_B : ALU_ADD;
        ctrl.wen    = 1'b1;
        use_imm     = 1'b1;
      end
      JAL: begin
        ctrl.imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
        ctrl.jump_instr = 1'b1;
        ctrl.wen        = 1'b1;
      end
      JALR: begin
        ctrl.imm        = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        ctrl.jump_instr = 1'b1;
        ctrl.jalr       = 1'b1;
        ctrl.wen        = 1'b1;
      end
      BRANCH: begin
        ctrl.imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
        ctrl.branch_instr = 1'b1;
        ctrl.branch_type  = branch_t'(instr.b_fmt.funct3);
      end
      LOAD: begin
        ctrl.imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        ctrl.dren      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.load_type = load_t'(instr.i_fmt.funct3);
        use_imm        = 1'b1;
      end
      STORE: begin
        ctrl.imm       = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
        ctrl.dwen      = 1'b1;
        ctrl.load_type = load_t'(instr.s_fmt.funct3);
        use_imm        = 1'b1;
      end
      OP_IMM: begin
        ctrl.imm    = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        // Bit 30 only matters for the right shift here
        ctrl.alu_op = arith_op(instr.i_fmt.funct3,
                               instr.r_fmt.funct7[5] && (instr.i_fmt.funct3 == 3'b101));
        ctrl.wen    = 1'b1;
        use_imm     = 1'b1;
      end
      OP: begin
        ctrl.alu_op = arith_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
        ctrl.wen    = 1'b1;
      end
      default: ;
    endcase

    if (ctrl.rd == '0)
      ctrl.wen = 1'b0;
  end

  assign rs1_val = fwd_value(bypass.rs1_fwd, id_ex.rs1_data, bypass.rd_data_mem,
                             bypass.rd_data_wb);
  assign rs2_val = fwd_value(bypass.rs2_fwd, id_ex.rs2_data, bypass.rd_data_mem,
                             bypass.rd_data_wb);

  always_comb begin
    ops.valid   = id_ex.valid;
    ops.ctrl    = ctrl;
    ops.rs1_val = rs1_val;
    ops.rs2_val = rs2_val;
    ops.alu_a   = (instr.r_fmt.opcode == AUIPC) ? id_ex.pc : rs1_val;
    ops.alu_b   = use_imm ? ctrl.imm : rs2_val;
    ops.pc      = id_ex.pc;
    ops.pc4     = id_ex.pc + 32'd4;
  end

endmodule

/* integer_alu.sv */
// Integer ALU
// Add, subtract, shifts, compares and logic ops for RV32I, plus a
// pass-through of operand b for LUI

`timescale 1ns/1ps

module integer_alu (
  input  ex_pkg::alu_op_t alu_op,
  input  ex_pkg::word_t   alu_a,
  input  ex_pkg::word_t   alu_b,
  output ex_pkg::word_t   alu_out
);

  import ex_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = alu_b[4:0];
  assign lt_signed   = $signed(alu_a) < $signed(alu_b);
  assign lt_unsigned = alu_a < alu_b;

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        alu_out = alu_a + alu_b;
      end
      ALU_SUB: begin
        alu_out = alu_a - alu_b;
      end
      ALU_SLL: begin
        alu_out = alu_a << shamt;
      end
      ALU_SLT: begin
        alu_out = {31'b0, lt_signed};
      end
      ALU_SLTU: begin
        alu_out = {31'b0, lt_unsigned};
      end
      ALU_XOR: begin
        alu_out = alu_a ^ alu_b;
      end
      ALU_SRL: begin
        alu_out = alu_a >> shamt;
      end
      ALU_SRA: begin
        // Arithmetic shift keeps the sign bit
        alu_out = word_t'($signed(alu_a) >>> shamt);
      end
      ALU_OR: begin
        alu_out = alu_a | alu_b;
      end
      ALU_AND: begin
        alu_out = alu_a & alu_b;
      end
      ALU_COPY_B: begin
        alu_out = alu_b;
      end
      default: begin
        alu_out = '0;
      end
    endcase
  end

endmodule

/* branch_resolve.sv */
// Branch and jump resolution
// Compares the forwarded sources per branch type and forms the
// branch target, the jump target and the next pc

`timescale 1ns/1ps

module branch_resolve (
  input  ex_pkg::ex_ops_t ops,
  output ex_pkg::br_res_t br
);

  import ex_pkg::*;

  logic  cond;
  logic  equal;
  logic  lt_signed;
  logic  lt_unsigned;
  word_t branch_addr;
  word_t jump_base;
  word_t jump_sum;

  assign equal       = ops.rs1_val == ops.rs2_val;
  assign lt_signed   = $signed(ops.rs1_val) < $signed(ops.rs2_val);
  assign lt_unsigned = ops.rs1_val < ops.rs2_val;

  always_comb begin
    case (ops.ctrl.branch_type)
      BEQ:     cond = equal;
      BNE:     cond = !equal;
      BLT:     cond = lt_signed;
      BGE:     cond = !lt_signed;
      BLTU:    cond = lt_unsigned;
      BGEU:    cond = !lt_unsigned;
      default: cond = 1'b0;
    endcase
  end

  assign branch_addr = ops.pc + ops.ctrl.imm;

  // JALR is relative to rs1 and drops bit 0
  assign jump_base = ops.ctrl.jalr ? ops.rs1_val : ops.pc;
  assign jump_sum  = jump_base + ops.ctrl.imm;

  always_comb begin
    br.branch_taken  = ops.ctrl.branch_instr && cond;
    br.jump_addr     = ops.ctrl.jalr ? {jump_sum[31:1], 1'b0} : jump_sum;
    br.resolved_addr = br.branch_taken ? branch_addr : ops.pc4;
  end

endmodule

/* ex_mem_latch.sv */
// Execute/memory pipeline register
// Forms the data byte enables and picks the writeback result, then
// holds the register under flush, halt, memory-done and advance

`timescale 1ns/1ps

module ex_mem_latch (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            advance,
  input  logic            flush,
  input  logic            halt,
  input  logic            mem_done,
  input  ex_pkg::ex_ops_t ops,
  input  ex_pkg::word_t   alu_out,
  input  ex_pkg::br_res_t br,
  output ex_pkg::ex_mem_t ex_mem
);

  import ex_pkg::*;

  logic [1:0] byte_offset;
  logic [3:0] byte_en;
  logic       mem_access;
  ex_mem_t    ex_mem_next;

  assign byte_offset = alu_out[1:0];
  assign mem_access  = ops.ctrl.dren || ops.ctrl.dwen;

  always_comb begin
    byte_en = 4'b0000;
    if (mem_access) begin
      case (ops.ctrl.load_type)
        LB, LBU: begin
          byte_en = 4'b0001 << byte_offset;
        end
        LH, LHU: begin
          // Odd halfword offsets get no enables
          case (byte_offset)
            2'b00:   byte_en = 4'b0011;
            2'b10:   byte_en = 4'b1100;
            default: byte_en = 4'b0000;
          endcase
        end
        LW: begin
          byte_en = 4'b1111;
        end
        default: begin
          byte_en = 4'b0000;
        end
      endcase
    end
  end

  always_comb begin
    ex_mem_next.valid         = ops.valid;
    ex_mem_next.wen           = ops.ctrl.wen;
    ex_mem_next.rd            = ops.ctrl.rd;
    ex_mem_next.result        = ops.ctrl.jump_instr ? ops.pc4 : alu_out;
    ex_mem_next.mem_addr      = alu_out;
    ex_mem_next.store_data    = ops.rs2_val;
    ex_mem_next.byte_en       = byte_en;
    ex_mem_next.dren          = ops.ctrl.dren;
    ex_mem_next.dwen          = ops.ctrl.dwen;
    ex_mem_next.load_type     = ops.ctrl.load_type;
    ex_mem_next.branch_instr  = ops.ctrl.branch_instr;
    ex_mem_next.branch_taken  = br.branch_taken;
    ex_mem_next.jump_instr    = ops.ctrl.jump_instr;
    ex_mem_next.jump_addr     = br.jump_addr;
    ex_mem_next.resolved_addr = br.resolved_addr;
    ex_mem_next.pc            = ops.pc;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= '0;
    end else if ((flush && advance) || halt) begin
      ex_mem <= '0;
    end else if (mem_done) begin
      // Release the data port, keep the rest
      ex_mem.dren <= 1'b0;
      ex_mem.dwen <= 1'b0;
    end else if (advance) begin
      ex_mem <= ex_mem_next;
    end
  end

endmodule

/* execute_stage.sv */
// RV32I execute stage
// Operand decode and forwarding, ALU, branch resolution and the
// execute/memory register

`timescale 1ns/1ps

module execute_stage (
  input  logic            CLK,
  input  logic            nRST,
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::bypass_t bypass,
  input  logic            advance,
  input  logic            flush,
  input  logic            halt,
  input  logic            mem_done,
  output ex_pkg::ex_mem_t ex_mem
);

  import ex_pkg::*;

  ex_ops_t ops;
  word_t   alu_out;
  br_res_t br;

  operand_decode u_decode (
    .id_ex  (id_ex),
    .bypass (bypass),
    .ops    (ops)
  );

  integer_alu u_alu (
    .alu_op  (ops.ctrl.alu_op),
    .alu_a   (ops.alu_a),
    .alu_b   (ops.alu_b),
    .alu_out (alu_out)
  );

  branch_resolve u_branch (
    .ops (ops),
    .br  (br)
  );

  ex_mem_latch u_latch (
    .CLK      (CLK),
    .nRST     (nRST),
    .advance  (advance),
    .flush    (flush),
    .halt     (halt),
    .mem_done (mem_done),
    .ops      (ops),
    .alu_out  (alu_out),
    .br       (br),
    .ex_mem   (ex_mem)
  );

endmodule

/* tb_execute_stage.sv */
// Testbench for the RV32I execute stage
// Drives instruction bundles, predicts ex_mem from the ISA rules and
// checks the execute/memory register with immediate assertions

`timescale 1ns/1ps

module tb_execute_stage;

  import ex_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int CHK_RD  = 1;
  localparam int CHK_RES = 2;
  localparam int CHK_MEM = 4;
  localparam int CHK_SD  = 8;
  localparam int CHK_JMP = 16;

  logic    CLK;
  logic    nRST;
  id_ex_t  id_ex;
  bypass_t bypass;
  logic    advance;
  logic    flush;
  logic    halt;
  logic    mem_done;
  ex_mem_t ex_mem;

  logic [31:0] lfsr_state;
  word_t       next_pc;
  int          checks;
  int          mismatches;
  int          failures;

  execute_stage uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .id_ex    (id_ex),
    .bypass   (bypass),
    .advance  (advance),
    .flush    (flush),
    .halt     (halt),
    .mem_done (mem_done),
    .ex_mem   (ex_mem)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic bypass_t make_bypass(input fwd_sel_t s1, input fwd_sel_t s2);
    bypass_t bp;
    bp.rs1_fwd     = s1;
    bp.rs2_fwd     = s2;
    bp.rd_data_mem = take_bits(32);
    bp.rd_data_wb  = take_bits(32);
    return bp;
  endfunction

  function automatic word_t pick_source(input fwd_sel_t sel, input word_t reg_val);
    word_t v;
    case (sel)
      FWD_M:   v = bypass.rd_data_mem;
      FWD_W:   v = bypass.rd_data_wb;
      default: v = reg_val;
    endcase
    return v;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: begin
        if (alt)
          r = word_t'($signed(a) >>> b[4:0]);
        else
          r = a >> b[4:0];
      end
    endcase
    return r;
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input word_t a, input word_t b);
    logic t;
    case (f3)
      3'b000:  t = (a == b);
      3'b001:  t = (a != b);
      3'b100:  t = ($signed(a) < $signed(b));
      3'b101:  t = ($signed(a) >= $signed(b));
      3'b110:  t = (a < b);
      3'b111:  t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  // Width from funct3 low bits, lane from the address offset
  function automatic logic [3:0] byte_lanes(input logic [2:0] f3, input logic [1:0] off);
    logic [3:0] lanes;
    case (f3[1:0])
      2'b00:   lanes = 4'b0001 << off;
      2'b01:   lanes = (off == 2'd0) ? 4'b0011 : ((off == 2'd2) ? 4'b1100 : 4'b0000);
      2'b10:   lanes = 4'b1111;
      default: lanes = 4'b0000;
    endcase
    return lanes;
  endfunction

  // Reference model on the currently driven inputs
  task automatic predict(input opcode_t op, input logic [2:0] f3, input logic alt,
                         input word_t imm, input logic [4:0] rd,
                         output ex_mem_t want, output int mask);
    word_t a;
    word_t b;
    word_t pc4;
    a   = pick_source(bypass.rs1_fwd, id_ex.rs1_data);
    b   = pick_source(bypass.rs2_fwd, id_ex.rs2_data);
    pc4 = id_ex.pc + 32'd4;
    want               = '0;
    want.valid         = id_ex.valid;
    want.pc            = id_ex.pc;
    want.rd            = rd;
    want.load_type     = NONE;
    want.resolved_addr = pc4;
    mask               = 0;
    case (op)
      LUI, AUIPC, OP, OP_IMM: begin
        if (op == LUI)
          want.result = imm;
        else if (op == AUIPC)
          want.result = id_ex.pc + imm;
        else if (op == OP)
          want.result = alu_ref(f3, alt, a, b);
        else
          want.result = alu_ref(f3, (f3 == 3'b101) && imm[10], a, imm);
        want.wen = 1'b1;
        mask     = CHK_RD | CHK_RES;
      end
      JAL, JALR: begin
        want.result     = pc4;
        want.wen        = 1'b1;
        want.jump_instr = 1'b1;
        want.jump_addr  = (op == JAL) ? id_ex.pc + imm : (a + imm) & ~32'd1;
        mask            = CHK_RD | CHK_RES | CHK_JMP;
      end
      BRANCH: begin
        want.branch_instr = 1'b1;
        want.branch_taken = taken_ref(f3, a, b);
        if (want.branch_taken)
          want.resolved_addr = id_ex.pc + imm;
      end
      LOAD, STORE: begin
        want.mem_addr  = a + imm;
        want.load_type = load_t'(f3);
        want.byte_en   = byte_lanes(f3, want.mem_addr[1:0]);
        if (op == LOAD) begin
          want.result = want.mem_addr;
          want.dren   = 1'b1;
          want.wen    = 1'b1;
          mask        = CHK_RD | CHK_RES | CHK_MEM;
        end else begin
          want.store_data = b;
          want.dwen       = 1'b1;
          mask            = CHK_MEM | CHK_SD;
        end
      end
      default: ;
    endcase
    if (rd == 5'd0)
      want.wen = 1'b0;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_bundle(input string what, input ex_mem_t want);
    checks++;
    assert (ex_mem === want) else begin
      mismatches++;
      $display("Mismatch at %0t: ex_mem (%s) is %h, expected %h", $time, what, ex_mem, want);
    end
  endtask

  task automatic compare(input ex_mem_t want, input int mask);
    check_field("wen", 32'(ex_mem.wen), 32'(want.wen));
    check_field("dren", 32'(ex_mem.dren), 32'(want.dren));
    check_field("dwen", 32'(ex_mem.dwen), 32'(want.dwen));
    check_field("branch_instr", 32'(ex_mem.branch_instr), 32'(want.branch_instr));
    check_field("branch_taken", 32'(ex_mem.branch_taken), 32'(want.branch_taken));
    check_field("jump_instr", 32'(ex_mem.jump_instr), 32'(want.jump_instr));
    check_field("byte_en", 32'(ex_mem.byte_en), 32'(want.byte_en));
    check_field("resolved_addr", ex_mem.resolved_addr, want.resolved_addr);
    if ((mask & CHK_RD) != 0)
      check_field("rd", 32'(ex_mem.rd), 32'(want.rd));
    if ((mask & CHK_RES) != 0)
      check_field("result", ex_mem.result, want.result);
    if ((mask & CHK_MEM) != 0) begin
      check_field("mem_addr", ex_mem.mem_addr, want.mem_addr);
      check_field("load_type", 32'(ex_mem.load_type), 32'(want.load_type));
    end
    if ((mask & CHK_SD) != 0)
      check_field("store_data", ex_mem.store_data, want.store_data);
    if ((mask & CHK_JMP) != 0)
      check_field("jump_addr", ex_mem.jump_addr, want.jump_addr);
  endtask

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic issue(input opcode_t op, input logic [2:0] f3, input logic alt,
                       input word_t imm, input logic [4:0] rd,
                       input word_t rs1_v, input word_t rs2_v, input bypass_t bp);
    logic [31:0] w;
    ex_mem_t     want;
    int          mask;
    int          edges;
    logic        seen;
    case (op)
      OP:         w = {alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, rd, op};
      STORE:      w = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op};
      BRANCH:     w = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op};
      LUI, AUIPC: w = {imm[31:12], rd, op};
      JAL:        w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      default:    w = {imm[11:0], 5'd1, f3, rd, op};
    endcase
    id_ex.valid    = 1'b1;
    id_ex.instr    = instr_word_u'(w);
    id_ex.pc       = next_pc;
    id_ex.rs1_data = rs1_v;
    id_ex.rs2_data = rs2_v;
    bypass         = bp;
    advance        = 1'b1;
    next_pc        = next_pc + 32'd4;
    predict(op, f3, alt, imm, rd, want, mask);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      advance = 1'b0;
      edges++;
      seen = ex_mem.valid && (ex_mem.pc == want.pc);
    end
    if (!seen) begin
      failures++;
      $display("Timeout at %0t: instruction at pc %h never reached ex_mem", $time, want.pc);
    end else begin
      checks++;
      assert (edges == 1) else begin
        failures++;
        $display("Latency error at %0t: pc %h took %0d cycles instead of one",
                 $time, want.pc, edges);
      end
      compare(want, mask);
    end
  endtask

  task automatic step(input logic adv, input logic fl, input logic hl, input logic md);
    advance  = adv;
    flush    = fl;
    halt     = hl;
    mem_done = md;
    @(posedge CLK);
    #1;
    advance  = 1'b0;
    flush    = 1'b0;
    halt     = 1'b0;
    mem_done = 1'b0;
  endtask

  initial begin
    bypass_t     no_fwd;
    ex_mem_t     saved;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [11:0] x;
    word_t       imm;
    word_t       r1;
    word_t       r2;
    lfsr_state = 32'h322e10a4;
    next_pc    = 32'h0000_0100;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    nRST       = 1'b0;
    id_ex      = '0;
    bypass     = '0;
    advance    = 1'b0;
    flush      = 1'b0;
    halt       = 1'b0;
    mem_done   = 1'b0;
    no_fwd     = '0;
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_bundle("after reset", '0);
    @(posedge CLK);
    #1;
    check_bundle("idle after reset", '0);

    // OP and OP-IMM with random operands
    for (int i = 0; i < 48; i++) begin
      f3  = 3'(take_bits(3));
      alt = 1'(take_bits(1)) && (f3 == 3'b000 || f3 == 3'b101);
      rd  = 5'(take_bits(5));
      r1  = take_bits(32);
      r2  = take_bits(32);
      if (i % 2 == 0) begin
        issue(OP, f3, alt, '0, rd, r1, r2, no_fwd);
      end else begin
        x = 12'(take_bits(12));
        if (f3 == 3'b001 || f3 == 3'b101)
          imm = {21'b0, alt, 5'b0, x[4:0]};
        else
          imm = {{20{x[11]}}, x};
        issue(OP_IMM, f3, 1'b0, imm, rd, r1, r2, no_fwd);
      end
    end
    issue(OP, 3'b000, 1'b0, '0, 5'd0, take_bits(32), take_bits(32), no_fwd);
    for (int i = 0; i < 4; i++) begin
      imm = take_bits(20) << 12;
      issue(LUI, 3'b000, 1'b0, imm, 5'(i + 3), '0, '0, no_fwd);
      issue(AUIPC, 3'b000, 1'b0, imm, 5'(i + 8), '0, '0, no_fwd);
    end

    // SUB shows operand order, memory value beats writeback
    for (int s1 = 0; s1 < 3; s1++) begin
      for (int s2 = 0; s2 < 3; s2++) begin
        r1 = take_bits(32);
        r2 = take_bits(32);
        issue(OP, 3'b000, 1'b1, '0, 5'd7, r1, r2,
              make_bypass(fwd_sel_t'(s1), fwd_sel_t'(s2)));
      end
    end

    // Branch codes 0 1 4 5 6 7, equal operands every third pass
    for (int i = 0; i < 36; i++) begin
      f3  = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
      r1  = take_bits(32);
      r2  = (i % 3 == 0) ? r1 : take_bits(32);
      imm = take_bits(12) << 1;
      imm = {{19{imm[12]}}, imm[12:0]};
      issue(BRANCH, f3, 1'b0, imm, 5'd0, r1, r2, no_fwd);
    end
    for (int i = 0; i < 8; i++) begin
      rd  = 5'(take_bits(5));
      r1  = take_bits(32);
      imm = take_bits(20) << 1;
      imm = {{11{imm[20]}}, imm[20:0]};
      issue(JAL, 3'b000, 1'b0, imm, rd, r1, '0, no_fwd);
      x = 12'(take_bits(12));
      issue(JALR, 3'b000, 1'b0, {{20{x[11]}}, x}, rd, r1, '0, no_fwd);
    end

    // Every width at every offset
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 5; k++) begin
        f3  = (k < 3) ? 3'(k) : 3'(k + 1);
        rd  = 5'(take_bits(5));
        r1  = take_bits(32) & ~32'd3;
        r2  = take_bits(32);
        x   = 12'(take_bits(12));
        imm = {{20{x[11]}}, x[11:2], 2'(off)};
        issue(LOAD, f3, 1'b0, imm, rd, r1, r2, no_fwd);
        if (k < 3)
          issue(STORE, f3, 1'b0, imm, 5'd0, r1, r2, no_fwd);
      end
    end

    // Pipeline control
    issue(OP, 3'b100, 1'b0, '0, 5'd9, take_bits(32), take_bits(32), no_fwd);
    saved = ex_mem;
    for (int i = 0; i < 3; i++) begin
      id_ex.pc       = take_bits(32);
      id_ex.rs1_data = take_bits(32);
      step(1'b0, 1'b0, 1'b0, 1'b0);
      check_bundle("advance low", saved);
    end
    step(1'b0, 1'b1, 1'b0, 1'b0);
    check_bundle("flush without advance", saved);
    step(1'b1, 1'b1, 1'b0, 1'b0);
    check_bundle("flush with advance", '0);
    issue(LOAD, 3'b010, 1'b0, 32'd8, 5'd3, 32'h0000_2000, '0, no_fwd);
    saved      = ex_mem;
    saved.dren = 1'b0;
    step(1'b1, 1'b0, 1'b0, 1'b1);
    check_bundle("mem_done after load", saved);
    issue(STORE, 3'b000, 1'b0, 32'd5, 5'd0, 32'h0000_3000, take_bits(32), no_fwd);
    saved      = ex_mem;
    saved.dwen = 1'b0;
    step(1'b0, 1'b0, 1'b0, 1'b1);
    check_bundle("mem_done after store", saved);
    step(1'b0, 1'b0, 1'b1, 1'b0);
    check_bundle("halt", '0);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* execute_stage.f */
ex_pkg.sv
operand_decode.sv
integer_alu.sv
branch_resolve.sv
ex_mem_latch.sv
execute_stage.sv
tb_execute_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_execute_stage \
  -f execute_stage.f \
  --Mdir obj_dir -o sim_exec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  echo "Testbench reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
